// File: hw/bypass_ctrl.sv
// Operand forwarding and decode stall for multiply hazards and write-back collisions
`timescale 1ns/1ps
`default_nettype none

`include "vi_core_macros.svh"

module bypass_ctrl import vi_core_pkg::*; (
	input  wire reg_addr_t rs1_i,
	input  wire reg_addr_t rs2_i,
	input  wire word_t     rf1_i,
	input  wire word_t     rf2_i,
	input  wire word_t     imm_i,
	input  wire dec_ctrl_t ctrl_i,
	input  wire wb_req_t   alu_fwd_i,
	input  wire wb_req_t   mult_fwd_i,
	input  wire wb_req_t   wb_fwd_i,
	input  wire mult_track_t [`VI_MULT_STAGES-1:0] mult_track_i,
	output exe_op_t        op_o,
	output logic           stall_o
);

	word_t opnd_a;
	word_t opnd_b;
	logic  hazard;
	logic  collide;

	// Youngest producer wins
	function automatic word_t pick(input reg_addr_t rs, input word_t rf);
		word_t v;
		v = rf;
		if (wb_fwd_i.valid && wb_fwd_i.rd == rs) begin
			v = wb_fwd_i.data;
		end
		if (mult_fwd_i.valid && mult_fwd_i.rd == rs) begin
			v = mult_fwd_i.data;
		end
		if (alu_fwd_i.valid && alu_fwd_i.rd == rs) begin
			v = alu_fwd_i.data;
		end
		return v;
	endfunction

	always_comb begin
		opnd_a = pick(rs1_i, rf1_i);
		opnd_b = pick(rs2_i, rf2_i);
	end

	// Multiplies from execute to stage 4 have no result yet
	always_comb begin
		hazard = 1'b0;
		for (int k = 0; k < `VI_MULT_STAGES; k++) begin
			if (mult_track_i[k].valid) begin
				if (rs1_i != '0 && mult_track_i[k].rd == rs1_i) begin
					hazard = 1'b1;
				end
				if (!ctrl_i.use_imm && rs2_i != '0 && mult_track_i[k].rd == rs2_i) begin
					hazard = 1'b1;
				end
				if (mult_track_i[k].rd == ctrl_i.rd) begin
					hazard = 1'b1;
				end
			end
		end
	end

	// ALU op now and multiply in stage 4 would both land in write-back
	assign collide = !ctrl_i.is_mul && mult_track_i[`VI_MULT_STAGES-1].valid;
	assign stall_o = ctrl_i.we & (hazard | collide);

	always_comb begin
		op_o.ctrl  = ctrl_i;
		op_o.a     = opnd_a;
		op_o.b     = ctrl_i.use_imm ? imm_i : opnd_b;
		op_o.valid = ctrl_i.we;
	end

endmodule

`default_nettype wire

// File: hw/decoder.sv
// Decode of the kept integer instructions into register indices, immediate and control
`timescale 1ns/1ps
`default_nettype none

`include "vi_core_macros.svh"

module decoder import vi_core_pkg::*; (
	input  wire word_t instr_i,
	input  wire logic  instr_valid_i,
	output reg_addr_t  rs1_o,
	output reg_addr_t  rs2_o,
	output word_t      imm_o,
	output dec_ctrl_t  ctrl_o
);

	opcode_e   opc;
	logic [2:0] f3;
	logic [6:0] f7;
	reg_addr_t  rd;
	logic       known;

	assign opc   = opcode_e'(instr_i[`VI_OPC_W-1:0]);
	assign f3    = instr_i[`VI_F3_LSB +: 3];
	assign f7    = instr_i[`VI_F7_LSB +: 7];
	assign rd    = instr_i[`VI_RD_LSB +: `VI_REG_AW];
	assign rs1_o = instr_i[`VI_RS1_LSB +: `VI_REG_AW];
	assign rs2_o = instr_i[`VI_RS2_LSB +: `VI_REG_AW];
	assign imm_o = word_t'($signed(instr_i[`VI_IMM_LSB +: `VI_IMM_W]));

	always_comb begin
		ctrl_o  = '0;
		known   = 1'b0;
		ctrl_o.rd = rd;
		case (opc)
			OPC_REG: begin
				known = 1'b1;
				case ({f7, f3})
					{7'b0000000, 3'b000}: ctrl_o.op = ALU_ADD;
					{7'b0100000, 3'b000}: ctrl_o.op = ALU_SUB;
					{7'b0000000, 3'b111}: ctrl_o.op = ALU_AND;
					{7'b0000000, 3'b110}: ctrl_o.op = ALU_OR;
					{7'b0000000, 3'b100}: ctrl_o.op = ALU_XOR;
					{7'b0000000, 3'b010}: ctrl_o.op = ALU_SLT;
					{7'b0000001, 3'b000}: begin
						ctrl_o.op     = ALU_MUL;
						ctrl_o.is_mul = 1'b1;
					end
					default: known = 1'b0;
				endcase
			end
			OPC_IMM: begin
				known          = 1'b1;
				ctrl_o.use_imm = 1'b1;
				case (f3)
					3'b000:  ctrl_o.op = ALU_ADD;
					3'b111:  ctrl_o.op = ALU_AND;
					3'b110:  ctrl_o.op = ALU_OR;
					3'b100:  ctrl_o.op = ALU_XOR;
					3'b010:  ctrl_o.op = ALU_SLT;
					default: known = 1'b0;
				endcase
			end
			default: known = 1'b0;
		endcase
		// Anything else, and any write to x0, is a no-op
		ctrl_o.we = instr_valid_i & known & (rd != '0);
	end

endmodule

`default_nettype wire

// File: hw/fetch.sv
// Sequential fetch with the instruction register that feeds decode
`timescale 1ns/1ps
`default_nettype none

module fetch import vi_core_pkg::*; (
	input  wire logic  clk_i,
	input  wire logic  rst_n_i,
	input  wire logic  stall_i,
	input  wire word_t imem_data_i,
	output word_t      imem_addr_o,
	output word_t      instr_o,
	output logic       instr_valid_o
);

	word_t pc_q;
	word_t instr_q;
	logic  valid_q;

	// Instruction memory is word addressed
	assign imem_addr_o = pc_q >> 2;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			pc_q    <= '0;
			valid_q <= 1'b0;
		end else if (!stall_i) begin
			pc_q    <= pc_q + 4;
			valid_q <= 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!stall_i) begin
			instr_q <= imem_data_i;
		end
	end

	assign instr_o       = instr_q;
	assign instr_valid_o = valid_q;

endmodule

`default_nettype wire

// File: hw/int_alu.sv
// Single-cycle integer ALU of the execute stage
`timescale 1ns/1ps
`default_nettype none

module int_alu import vi_core_pkg::*; (
	input  wire exe_op_t op_i,
	output wb_req_t      res_o
);

	word_t result;

	always_comb begin
		case (op_i.ctrl.op)
			ALU_ADD: result = op_i.a + op_i.b;
			ALU_SUB: result = op_i.a - op_i.b;
			ALU_AND: result = op_i.a & op_i.b;
			ALU_OR:  result = op_i.a | op_i.b;
			ALU_XOR: result = op_i.a ^ op_i.b;
			ALU_SLT: result = word_t'($signed(op_i.a) < $signed(op_i.b));
			default: result = '0;
		endcase
	end

	// Multiplies leave through the multiply pipe
	assign res_o.valid = op_i.valid & ~op_i.ctrl.is_mul;
	assign res_o.rd    = op_i.ctrl.rd;
	assign res_o.data  = result;

endmodule

`default_nettype wire

// File: hw/int_registers.sv
// Integer register file, read combinationally in decode and written from write-back
`timescale 1ns/1ps
`default_nettype none

`include "vi_core_macros.svh"

module int_registers import vi_core_pkg::*; (
	input  wire logic      clk_i,
	input  wire logic      rst_n_i,
	input  wire reg_addr_t rs1_i,
	input  wire reg_addr_t rs2_i,
	input  wire wb_req_t   wr_i,
	output word_t          rd1_o,
	output word_t          rd2_o
);

	word_t regs_q [`VI_NREGS];

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			for (int r = 0; r < `VI_NREGS; r++) begin
				regs_q[r] <= '0;
			end
		end else if (wr_i.valid && wr_i.rd != '0) begin
			regs_q[wr_i.rd] <= wr_i.data;
		end
	end

	// Old contents on a same-cycle write, the bypass covers the new value
	assign rd1_o = regs_q[rs1_i];
	assign rd2_o = regs_q[rs2_i];

endmodule

`default_nettype wire

// File: hw/mult_pipe.sv
// Fixed-latency multiply pipeline, product formed in stage 1 and carried to stage 5
`timescale 1ns/1ps
`default_nettype none

`include "vi_core_macros.svh"

module mult_pipe import vi_core_pkg::*; (
	input  wire logic    clk_i,
	input  wire logic    rst_n_i,
	input  wire exe_op_t op_i,
	output wb_req_t      res_o,
	output mult_track_t [`VI_MULT_STAGES-1:0] track_o
);

	mult_track_t trk_q [1:`VI_MULT_STAGES];
	word_t       prod_q [1:`VI_MULT_STAGES];
	logic        take;

	assign take = op_i.valid & op_i.ctrl.is_mul;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			for (int s = 1; s <= `VI_MULT_STAGES; s++) begin
				trk_q[s] <= '0;
			end
		end else begin
			trk_q[1].valid <= take;
			trk_q[1].rd    <= op_i.ctrl.rd;
			for (int s = 2; s <= `VI_MULT_STAGES; s++) begin
				trk_q[s] <= trk_q[s-1];
			end
		end
	end

	// Low 32 bits only
	always_ff @(posedge clk_i) begin
		prod_q[1] <= op_i.a * op_i.b;
		for (int s = 2; s <= `VI_MULT_STAGES; s++) begin
			prod_q[s] <= prod_q[s-1];
		end
	end

	// Entry 0 is the multiply still in execute
	always_comb begin
		track_o[0].valid = take;
		track_o[0].rd    = op_i.ctrl.rd;
		for (int s = 1; s < `VI_MULT_STAGES; s++) begin
			track_o[s] = trk_q[s];
		end
	end

	assign res_o.valid = trk_q[`VI_MULT_STAGES].valid;
	assign res_o.rd    = trk_q[`VI_MULT_STAGES].rd;
	assign res_o.data  = prod_q[`VI_MULT_STAGES];

endmodule

`default_nettype wire

// File: hw/vi_core.sv
// Top of the in-order integer core, fetch to write-back, with the instruction port
`timescale 1ns/1ps
`default_nettype none

`include "vi_core_macros.svh"

module vi_core import vi_core_pkg::*; (
	input  wire logic  clk_i,
	input  wire logic  rst_n_i,
	input  wire word_t imem_data_i,
	output word_t      imem_addr_o,
	output wb_req_t    wb_o
);

	// Fetch and decode
	word_t     instr;
	logic      instr_valid;
	reg_addr_t rs1;
	reg_addr_t rs2;
	word_t     imm;
	dec_ctrl_t dec_ctrl;
	word_t     rf1;
	word_t     rf2;
	exe_op_t   dec_op;
	logic      stall;

	// Execute and write-back
	exe_op_t   exe_q;
	wb_req_t   alu_res;
	wb_req_t   mult_res;
	wb_req_t   wb_q;
	mult_track_t [`VI_MULT_STAGES-1:0] mult_track;

	fetch fetch (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.stall_i       (stall),
		.imem_data_i   (imem_data_i),
		.imem_addr_o   (imem_addr_o),
		.instr_o       (instr),
		.instr_valid_o (instr_valid)
	);

	decoder decoder (
		.instr_i       (instr),
		.instr_valid_i (instr_valid),
		.rs1_o         (rs1),
		.rs2_o         (rs2),
		.imm_o         (imm),
		.ctrl_o        (dec_ctrl)
	);

	int_registers int_registers (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.rs1_i   (rs1),
		.rs2_i   (rs2),
		.wr_i    (wb_q),
		.rd1_o   (rf1),
		.rd2_o   (rf2)
	);

	bypass_ctrl bypass_ctrl (
		.rs1_i        (rs1),
		.rs2_i        (rs2),
		.rf1_i        (rf1),
		.rf2_i        (rf2),
		.imm_i        (imm),
		.ctrl_i       (dec_ctrl),
		.alu_fwd_i    (alu_res),
		.mult_fwd_i   (mult_res),
		.wb_fwd_i     (wb_q),
		.mult_track_i (mult_track),
		.op_o         (dec_op),
		.stall_o      (stall)
	);

	// A stalled decode sends a bubble into execute
	always_ff @(posedge clk_i) begin
		if (!rst_n_i || stall) begin
			exe_q <= '0;
		end else begin
			exe_q <= dec_op;
		end
	end

	int_alu int_alu (
		.op_i  (exe_q),
		.res_o (alu_res)
	);

	mult_pipe mult_pipe (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.op_i    (exe_q),
		.res_o   (mult_res),
		.track_o (mult_track)
	);

	// Stall rule 3 keeps these two exclusive
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			wb_q <= '0;
		end else begin
			wb_q <= mult_res.valid ? mult_res : alu_res;
		end
	end

	assign wb_o = wb_q;

endmodule

`default_nettype wire

// File: hw/vi_core_macros.svh
// Core-wide widths and instruction field positions, included by the package and RTL
`ifndef VI_CORE_MACROS_SVH
`define VI_CORE_MACROS_SVH

// Datapath and register file sizes
`define VI_XLEN        32
`define VI_REG_AW      5
`define VI_NREGS       32

// Multiply latency in stages after execute
`define VI_MULT_STAGES 5

// RV32 instruction fields
`define VI_OPC_W       7
`define VI_RD_LSB      7
`define VI_F3_LSB      12
`define VI_RS1_LSB     15
`define VI_RS2_LSB     20
`define VI_F7_LSB      25
`define VI_IMM_LSB     20
`define VI_IMM_W       12

`endif

// File: hw/vi_core_pkg.sv
// Shared types of the integer pipeline, imported by the core modules and the testbench
`default_nettype none

`include "vi_core_macros.svh"

package vi_core_pkg;

	typedef logic [`VI_XLEN-1:0]   word_t;
	typedef logic [`VI_REG_AW-1:0] reg_addr_t;

	// Major opcodes that survive decode
	typedef enum logic [`VI_OPC_W-1:0] {
		OPC_NONE = 7'b0000000,
		OPC_REG  = 7'b0110011,
		OPC_IMM  = 7'b0010011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_OR  = 4'd3,
		ALU_XOR = 4'd4,
		ALU_SLT = 4'd5,
		ALU_MUL = 4'd6
	} alu_op_e;

	typedef struct packed {
		alu_op_e   op;
		logic      use_imm;
		logic      we;
		reg_addr_t rd;
		logic      is_mul;
	} dec_ctrl_t;

	typedef struct packed {
		dec_ctrl_t ctrl;
		word_t     a;
		word_t     b;
		logic      valid;
	} exe_op_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		word_t     data;
	} wb_req_t;

	// What a multiply stage holds, seen by the hazard logic
	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
	} mult_track_t;

endpackage

`default_nettype wire

// File: project.f
+incdir+hw
hw/vi_core_pkg.sv
hw/fetch.sv
hw/decoder.sv
hw/int_registers.sv
hw/bypass_ctrl.sv
hw/int_alu.sv
hw/mult_pipe.sv
hw/vi_core.sv
verif/vi_core_assertions.sv
verif/vi_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module vi_core_tb -o vi_core_sim

out=$(./obj_dir/vi_core_sim 2>&1) || true
echo "$out"

if grep -qF "*** TEST PASSED ***" <<< "$out"; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// File: verif/vi_core_assertions.sv
// Concurrent checks on write-back of the core, bound into every instance of the top level
`timescale 1ns/1ps
`default_nettype none

module vi_core_assertions import vi_core_pkg::*; (
	input wire logic    clk_i,
	input wire logic    rst_n_i,
	input wire wb_req_t alu_res_i,
	input wire wb_req_t mult_res_i,
	input wire wb_req_t wb_i
);

	// The stall rule keeps the two write-back sources apart
	one_wb_source: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(alu_res_i.valid && mult_res_i.valid))
		else $error("ALU and multiply results are valid in the same cycle");

	no_x0_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_i.valid |-> wb_i.rd != '0)
		else $error("Write-back targets register x0");

	quiet_in_reset: assert property (@(posedge clk_i)
		(!rst_n_i && !$past(rst_n_i)) |-> !wb_i.valid)
		else $error("Write-back is valid while reset is asserted");

endmodule

bind vi_core vi_core_assertions vi_core_assertions_i (
	.clk_i      (clk_i),
	.rst_n_i    (rst_n_i),
	.alu_res_i  (alu_res),
	.mult_res_i (mult_res),
	.wb_i       (wb_o)
);

`default_nettype wire

// File: verif/vi_core_tb.sv
// Top-level testbench of the integer core that runs a directed and a random program
`timescale 1ns/1ps
`default_nettype none

module vi_core_tb import vi_core_pkg::*; ();

	localparam int    N_DIR       = 20;
	localparam int    N_ALU       = 13;
	localparam int    N_RAND      = 200;
	localparam int    PROG_LEN    = N_DIR + N_RAND;
	localparam int    DRAIN_LIMIT = 2000;
	localparam word_t NOP         = 32'h0000_0013;

	// One program row with the write it should produce
	typedef struct packed {
		word_t     instr;
		reg_addr_t rd;
		word_t     exp;
	} row_t;

	logic    clk;
	logic    rst_n;
	word_t   imem_data;
	word_t   imem_addr;
	wb_req_t wb;

	row_t  rows [PROG_LEN];
	word_t prog_mem [256];
	word_t model_regs [32] = '{default: '0};
	word_t last_data [32] = '{default: '0};
	int    next_row [32] = '{default: 0};
	int    seed;
	int    n_rows = 0;
	int    edges = 0;
	int    writes = 0;
	int    exp_writes = 0;
	int    checks = 0;
	int    errors = 0;

	vi_core vi_core_i (
		.clk_i       (clk),
		.rst_n_i     (rst_n),
		.imem_data_i (imem_data),
		.imem_addr_o (imem_addr),
		.wb_o        (wb)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Instruction memory returning no-ops past the program
	always_comb begin
		if (imem_addr < PROG_LEN) begin
			imem_data = prog_mem[imem_addr[7:0]];
		end else begin
			imem_data = NOP;
		end
	end

	task automatic check_word(input string name, input word_t exp, input word_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Mismatch %s: expected x%0d, actual x%0d", name, exp, act);
		end
	endtask

	task automatic check_valid(input string name, input logic exp, input logic act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Mismatch %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	// Writes to one register arrive in program order
	task automatic match_program_order(input reg_addr_t rd, input word_t data);
		int i;
		i = next_row[rd];
		while (i < PROG_LEN && (rd == '0 || rows[i].rd != rd)) begin
			i++;
		end
		if (i < PROG_LEN) begin
			check_word($sformatf("row%0d_write", i), rows[i].exp, data);
			next_row[rd] = i + 1;
		end else begin
			errors++;
			$display("Unexpected write of %h to x%0d beyond the writes of the program",
				data, rd);
		end
	endtask

	function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
			input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic word_t enc_i(input logic [11:0] imm, input logic [2:0] f3,
			input reg_addr_t rd, input reg_addr_t rs1);
		return {imm, rs1, f3, rd, 7'h13};
	endfunction

	task automatic add_row(input word_t instr, input reg_addr_t rd, input word_t exp);
		rows[n_rows] = '{instr, rd, exp};
		n_rows++;
	endtask

	// Reference model of one instruction that returns true when it writes a register
	function automatic logic model_exec(input word_t ins, input word_t a, input word_t rb,
			output word_t res);
		word_t b;
		logic  known;
		b = (ins[6:0] == 7'h13) ? {{20{ins[31]}}, ins[31:20]} : rb;
		known = 1'b1;
		res = '0;
		if (ins[6:0] == 7'h33 && ins[31:25] == 7'h01 && ins[14:12] == 3'd0) begin
			res = a * b;
		end else if (ins[6:0] == 7'h33 && ins[31:25] == 7'h20 && ins[14:12] == 3'd0) begin
			res = a - b;
		end else if ((ins[6:0] == 7'h33 && ins[31:25] == 7'h00) || ins[6:0] == 7'h13) begin
			case (ins[14:12])
				3'd0: res = a + b;
				3'd7: res = a & b;
				3'd6: res = a | b;
				3'd4: res = a ^ b;
				3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				default: known = 1'b0;
			endcase
		end else begin
			known = 1'b0;
		end
		return known && ins[11:7] != 5'd0;
	endfunction

	// Registers x0 to x7 only so that hazards come often
	function automatic word_t random_instr();
		word_t     r;
		reg_addr_t rd;
		reg_addr_t rs1;
		reg_addr_t rs2;
		r = $random(seed);
		rd = {2'b00, r[6:4]};
		rs1 = {2'b00, r[9:7]};
		rs2 = {2'b00, r[12:10]};
		case (r[3:0])
			4'd0, 4'd1, 4'd2: return enc_r(7'h01, 3'd0, rd, rs1, rs2);
			4'd3: return enc_r(7'h00, 3'd0, rd, rs1, rs2);
			4'd4: return enc_r(7'h20, 3'd0, rd, rs1, rs2);
			4'd5: return enc_r(7'h00, 3'd7, rd, rs1, rs2);
			4'd6: return enc_r(7'h00, 3'd6, rd, rs1, rs2);
			4'd7: return enc_r(7'h00, 3'd4, rd, rs1, rs2);
			4'd8: return enc_r(7'h00, 3'd2, rd, rs1, rs2);
			4'd9: return enc_i(r[24:13], 3'd0, rd, rs1);
			4'd10: return enc_i(r[24:13], 3'd7, rd, rs1);
			4'd11: return enc_i(r[24:13], 3'd6, rd, rs1);
			4'd12: return enc_i(r[24:13], 3'd4, rd, rs1);
			4'd13: return enc_i(r[24:13], 3'd2, rd, rs1);
			default: return {r[31:7], 7'h63};
		endcase
	endfunction

	always @(posedge clk) begin
		if (rst_n) begin
			edges <= edges + 1;
		end
	end

	// The leading ALU rows land on write-back exactly three cycles after fetch
	always @(negedge clk) begin
		if (edges > 0 && edges < 3) begin
			check_valid($sformatf("idle_cycle%0d", edges), 1'b0, wb.valid);
		end else if (edges >= 3 && edges - 3 < N_ALU) begin
			check_valid($sformatf("row%0d_valid", edges - 3), 1'b1, wb.valid);
			check_reg($sformatf("row%0d_rd", edges - 3), rows[edges - 3].rd, wb.rd);
			check_word($sformatf("row%0d_data", edges - 3), rows[edges - 3].exp, wb.data);
		end
		if (edges > 0 && wb.valid) begin
			writes++;
			last_data[wb.rd] = wb.data;
			match_program_order(wb.rd, wb.data);
		end
	end

	initial begin
		word_t val;
		logic  wr;
		int    t;
		rst_n = 1'b0;
		seed = 32'h9b52_1894;
		add_row(enc_i(12'd5, 3'd0, 5'd1, 5'd0), 5'd1, 32'h0000_0005);
		add_row(enc_i(12'hffd, 3'd0, 5'd2, 5'd0), 5'd2, 32'hffff_fffd);
		add_row(enc_r(7'h00, 3'd0, 5'd3, 5'd1, 5'd2), 5'd3, 32'h0000_0002);
		add_row(enc_r(7'h20, 3'd0, 5'd4, 5'd3, 5'd1), 5'd4, 32'hffff_fffd);
		add_row(enc_r(7'h00, 3'd2, 5'd5, 5'd4, 5'd1), 5'd5, 32'h0000_0001);
		add_row(enc_r(7'h00, 3'd2, 5'd6, 5'd1, 5'd4), 5'd6, 32'h0000_0000);
		add_row(enc_r(7'h00, 3'd4, 5'd7, 5'd4, 5'd2), 5'd7, 32'h0000_0000);
		add_row(enc_i(12'h0f0, 3'd6, 5'd7, 5'd7), 5'd7, 32'h0000_00f0);
		add_row(enc_i(12'h0ff, 3'd7, 5'd8, 5'd2), 5'd8, 32'h0000_00fd);
		add_row(enc_r(7'h00, 3'd6, 5'd9, 5'd8, 5'd7), 5'd9, 32'h0000_00fd);
		add_row(enc_r(7'h00, 3'd7, 5'd10, 5'd9, 5'd2), 5'd10, 32'h0000_00fd);
		add_row(enc_i(12'hfff, 3'd2, 5'd11, 5'd2), 5'd11, 32'h0000_0001);
		add_row(enc_i(12'hfff, 3'd4, 5'd12, 5'd1), 5'd12, 32'hffff_fffa);
		// Multiplies with a dependent use and a rewrite of the same register
		add_row(enc_r(7'h01, 3'd0, 5'd13, 5'd1, 5'd2), 5'd13, 32'hffff_fff1);
		add_row(enc_r(7'h00, 3'd0, 5'd14, 5'd13, 5'd1), 5'd14, 32'hffff_fff6);
		add_row(enc_r(7'h01, 3'd0, 5'd15, 5'd12, 5'd12), 5'd15, 32'h0000_0024);
		add_row(enc_i(12'd7, 3'd0, 5'd15, 5'd0), 5'd15, 32'h0000_0007);
		add_row(enc_r(7'h01, 3'd0, 5'd16, 5'd15, 5'd4), 5'd16, 32'hffff_ffeb);
		add_row(enc_i(12'd1, 3'd0, 5'd17, 5'd3), 5'd17, 32'h0000_0003);
		add_row(enc_r(7'h01, 3'd0, 5'd17, 5'd17, 5'd17), 5'd17, 32'h0000_0009);
		for (int i = 0; i < PROG_LEN; i++) begin
			if (i >= N_DIR) begin
				rows[i].instr = random_instr();
			end
			wr = model_exec(rows[i].instr, model_regs[rows[i].instr[19:15]],
				model_regs[rows[i].instr[24:20]], val);
			if (i >= N_DIR) begin
				rows[i].rd = wr ? rows[i].instr[11:7] : 5'd0;
				rows[i].exp = val;
			end
			if (wr) begin
				model_regs[rows[i].instr[11:7]] = val;
				exp_writes++;
			end
			prog_mem[i] = rows[i].instr;
		end
		repeat (5) @(posedge clk);
		@(negedge clk);
		check_word("reset_addr", '0, imem_addr);
		check_valid("reset_wb_valid", 1'b0, wb.valid);
		rst_n = 1'b1;
		t = 0;
		while (imem_addr < PROG_LEN + 10 && t < DRAIN_LIMIT) begin
			@(negedge clk);
			t++;
		end
		if (imem_addr < PROG_LEN + 10) begin
			$display("Timeout: the core did not run past the end of the program");
			$display("*** TEST FAILED ***");
			$finish;
		end else begin
			@(posedge clk);
			for (int r = 1; r < 32; r++) begin
				check_word($sformatf("final_x%0d", r), model_regs[r], last_data[r]);
			end
			check_word("write_count", word_t'(exp_writes), word_t'(writes));
			$display("Checks: %0d, mismatches: %0d, writes seen: %0d", checks, errors, writes);
			if (errors == 0) begin
				$display("*** TEST PASSED ***");
			end else begin
				$display("*** TEST FAILED ***");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire
